/* src/issue_pkg.sv */
package issue_pkg;

  // queue geometry
  localparam int queue_depth = 8;
  localparam int index_width = $clog2(queue_depth);
  localparam int count_width = index_width + 1;
  // fetch stall rises once more than half the entries are in use
  localparam logic [count_width-1:0] stall_threshold = count_width'(queue_depth / 2);

  // addi x0,x0,0
  localparam logic [31:0] nop_instr = 32'h0000_0013;

  // base and floating-point opcodes
  localparam logic [6:0] opcode_lui       = 7'b0110111;
  localparam logic [6:0] opcode_auipc     = 7'b0010111;
  localparam logic [6:0] opcode_jal       = 7'b1101111;
  localparam logic [6:0] opcode_jalr      = 7'b1100111;
  localparam logic [6:0] opcode_branch    = 7'b1100011;
  localparam logic [6:0] opcode_load      = 7'b0000011;
  localparam logic [6:0] opcode_store     = 7'b0100011;
  localparam logic [6:0] opcode_immediate = 7'b0010011;
  localparam logic [6:0] opcode_register  = 7'b0110011;
  localparam logic [6:0] opcode_fence     = 7'b0001111;
  localparam logic [6:0] opcode_system    = 7'b1110011;
  localparam logic [6:0] opcode_fload     = 7'b0000111;
  localparam logic [6:0] opcode_fstore    = 7'b0100111;
  localparam logic [6:0] opcode_fp        = 7'b1010011;
  localparam logic [6:0] opcode_fmadd     = 7'b1000011;
  localparam logic [6:0] opcode_fmsub     = 7'b1000111;
  localparam logic [6:0] opcode_fnmsub    = 7'b1001011;
  localparam logic [6:0] opcode_fnmadd    = 7'b1001111;

  // integer alu funct3
  localparam logic [2:0] funct3_add  = 3'b000;
  localparam logic [2:0] funct3_sll  = 3'b001;
  localparam logic [2:0] funct3_slt  = 3'b010;
  localparam logic [2:0] funct3_sltu = 3'b011;
  localparam logic [2:0] funct3_xor  = 3'b100;
  localparam logic [2:0] funct3_srl  = 3'b101;
  localparam logic [2:0] funct3_or   = 3'b110;
  localparam logic [2:0] funct3_and  = 3'b111;

  // floating-point operation codes, upper five bits of funct7
  localparam logic [4:0] funct5_fadd      = 5'b00000;
  localparam logic [4:0] funct5_fsub      = 5'b00001;
  localparam logic [4:0] funct5_fmul      = 5'b00010;
  localparam logic [4:0] funct5_fdiv      = 5'b00011;
  localparam logic [4:0] funct5_fsqrt     = 5'b01011;
  localparam logic [4:0] funct5_fsgnj     = 5'b00100;
  localparam logic [4:0] funct5_fminmax   = 5'b00101;
  localparam logic [4:0] funct5_fcomp     = 5'b10100;
  localparam logic [4:0] funct5_fmv_f2i   = 5'b11100;
  localparam logic [4:0] funct5_fmv_i2f   = 5'b11110;
  localparam logic [4:0] funct5_fconv_f2i = 5'b11000;
  localparam logic [4:0] funct5_fconv_i2f = 5'b11010;

  localparam logic [6:0] funct7_base = 7'b0000000;
  // sub and sra
  localparam logic [6:0] funct7_alt  = 7'b0100000;

  // return address registers, used for the call and return hints
  localparam logic [4:0] link_reg_ra = 5'd1;
  localparam logic [4:0] link_reg_t0 = 5'd5;

  // one instruction word, read as an integer or a floating-point encoding
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } int_form;
    struct packed {
      logic [4:0] funct5;
      logic [1:0] fmt;
      logic [4:0] rs2;
      logic [4:0] rs1;
      // rounding mode for most fp operations
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } fp_form;
  } instr_word_t;

endpackage

/* src/fetch_queue.sv */
`timescale 1ns/1ps

module fetch_queue (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   clear,
  input  logic                   ready,
  input  logic [31:0]            fetch_pc,
  input  logic [63:0]            fetch_rdata,
  input  logic [1:0]             take,
  output logic [31:0]            head_pc0,
  output logic [31:0]            head_pc1,
  output issue_pkg::instr_word_t head_instr0,
  output issue_pkg::instr_word_t head_instr1,
  output logic [1:0]             head_valid,
  output logic                   fetch_stall
);

  import issue_pkg::*;

  logic [31:0]            pc_mem [queue_depth];
  instr_word_t            instr_mem [queue_depth];

  logic [index_width-1:0] wr_ptr;
  logic [index_width-1:0] wr_ptr_hi;
  logic [index_width-1:0] rd_ptr;
  logic [index_width-1:0] rd_ptr_hi;
  logic [count_width-1:0] count;
  logic [count_width-1:0] count_next;
  logic                   accept;

  // a word offered during a stall is dropped, fetch has to replay it
  assign accept = ready & ~fetch_stall & ~clear;

  assign wr_ptr_hi = wr_ptr + index_width'(1);
  assign rd_ptr_hi = rd_ptr + index_width'(1);

  always_comb begin
    count_next = count - count_width'(take);
    if (accept) begin
      count_next = count_next + count_width'(2);
    end
    if (clear) begin
      count_next = '0;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      count       <= '0;
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      fetch_stall <= 1'b0;
    end else begin
      count       <= count_next;
      fetch_stall <= count_next > stall_threshold;
      if (clear) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
      end else begin
        rd_ptr <= rd_ptr + index_width'(take);
        if (accept) begin
          wr_ptr <= wr_ptr + index_width'(2);
        end
      end
    end
  end

  // low half sits at fetch_pc, high half at fetch_pc+4
  always_ff @(posedge clock) begin
    if (accept) begin
      pc_mem[wr_ptr]       <= fetch_pc;
      instr_mem[wr_ptr]    <= fetch_rdata[31:0];
      pc_mem[wr_ptr_hi]    <= fetch_pc + 32'd4;
      instr_mem[wr_ptr_hi] <= fetch_rdata[63:32];
    end
  end

  assign head_valid[0] = count > count_width'(0);
  assign head_valid[1] = count > count_width'(1);

  assign head_pc0    = head_valid[0] ? pc_mem[rd_ptr] : 32'd0;
  assign head_pc1    = head_valid[1] ? pc_mem[rd_ptr_hi] : 32'd0;
  assign head_instr0 = head_valid[0] ? instr_mem[rd_ptr] : nop_instr;
  assign head_instr1 = head_valid[1] ? instr_mem[rd_ptr_hi] : nop_instr;

endmodule

/* src/slot_decoder.sv */
`timescale 1ns/1ps

module slot_decoder (
  input  issue_pkg::instr_word_t instr,
  output logic                   basic,
  output logic                   complex,
  output logic                   wren,
  output logic                   rden1,
  output logic                   rden2,
  output logic                   return_pop,
  output logic                   return_push,
  output logic                   jump_uncond,
  output logic                   jump_rest,
  output logic                   branch
);

  import issue_pkg::*;

  logic rd_nonzero;
  logic link_rd;
  logic link_rs1;

  assign rd_nonzero = |instr.int_form.rd;
  assign link_rd    = (instr.int_form.rd == link_reg_ra) | (instr.int_form.rd == link_reg_t0);
  assign link_rs1   = (instr.int_form.rs1 == link_reg_ra) | (instr.int_form.rs1 == link_reg_t0);

  always_comb begin
    basic       = 1'b0;
    complex     = 1'b0;
    wren        = 1'b0;
    rden1       = 1'b0;
    rden2       = 1'b0;
    return_pop  = 1'b0;
    return_push = 1'b0;
    jump_uncond = 1'b0;
    jump_rest   = 1'b0;
    branch      = 1'b0;

    case (instr.int_form.opcode)
      opcode_lui, opcode_auipc: begin
        complex = 1'b1;
        wren    = rd_nonzero;
      end
      opcode_jal: begin
        complex     = 1'b1;
        wren        = rd_nonzero;
        return_push = link_rd;
        jump_uncond = ~rd_nonzero;
        jump_rest   = ~(link_rd | ~rd_nonzero);
      end
      opcode_jalr: begin
        complex     = 1'b1;
        wren        = rd_nonzero;
        rden1       = 1'b1;
        return_pop  = link_rs1;
        return_push = link_rd;
        jump_rest   = ~link_rd;
      end
      opcode_branch: begin
        complex = 1'b1;
        rden1   = 1'b1;
        rden2   = 1'b1;
        branch  = 1'b1;
      end
      opcode_load: begin
        complex = 1'b1;
        wren    = rd_nonzero;
        rden1   = 1'b1;
      end
      opcode_store: begin
        complex = 1'b1;
        rden1   = 1'b1;
        rden2   = 1'b1;
      end
      opcode_immediate: begin
        wren  = rd_nonzero;
        rden1 = 1'b1;
        case (instr.int_form.funct3)
          funct3_add, funct3_slt, funct3_sltu, funct3_and, funct3_or, funct3_xor: begin
            basic = 1'b1;
          end
          funct3_sll: begin
            basic = instr.int_form.funct7 == funct7_base;
          end
          funct3_srl: begin
            basic = (instr.int_form.funct7 == funct7_base) |
                    (instr.int_form.funct7 == funct7_alt);
          end
          default: begin
            basic = 1'b0;
          end
        endcase
        complex = ~basic;
      end
      opcode_register: begin
        wren  = rd_nonzero;
        rden1 = 1'b1;
        rden2 = 1'b1;
        if (instr.int_form.funct7 == funct7_base) begin
          basic = 1'b1;
        end else if (instr.int_form.funct7 == funct7_alt) begin
          // sub and sra
          basic = (instr.int_form.funct3 == funct3_add) |
                  (instr.int_form.funct3 == funct3_srl);
        end
        // includes the multiply and divide group
        complex = ~basic;
      end
      opcode_fence: begin
        complex = 1'b1;
      end
      opcode_system: begin
        complex = 1'b1;
        case (instr.int_form.funct3)
          // csrrw, csrrs, csrrc take rs1
          3'd1, 3'd2, 3'd3: begin
            wren  = rd_nonzero;
            rden1 = 1'b1;
          end
          // immediate csr forms
          3'd5, 3'd6, 3'd7: begin
            wren = rd_nonzero;
          end
          default: begin
            wren = 1'b0;
          end
        endcase
      end
      opcode_fload, opcode_fstore: begin
        complex = 1'b1;
        rden1   = 1'b1;
      end
      opcode_fp: begin
        case (instr.fp_form.funct5)
          funct5_fadd, funct5_fsub, funct5_fmul, funct5_fdiv, funct5_fsqrt,
          funct5_fsgnj, funct5_fminmax: begin
            complex = 1'b1;
          end
          // results land in the integer file even for rd x0
          funct5_fcomp, funct5_fmv_f2i, funct5_fconv_f2i: begin
            complex = 1'b1;
            wren    = 1'b1;
          end
          funct5_fmv_i2f, funct5_fconv_i2f: begin
            complex = 1'b1;
            rden1   = 1'b1;
          end
          default: begin
            complex = 1'b0;
          end
        endcase
      end
      opcode_fmadd, opcode_fmsub, opcode_fnmsub, opcode_fnmadd: begin
        complex = 1'b1;
      end
      default: begin
        complex = 1'b0;
      end
    endcase
  end

endmodule

/* src/pair_issue.sv */
`timescale 1ns/1ps

module pair_issue (
  input  logic                   issue_hold,
  input  logic [31:0]            head_pc0,
  input  logic [31:0]            head_pc1,
  input  issue_pkg::instr_word_t head_instr0,
  input  issue_pkg::instr_word_t head_instr1,
  input  logic [1:0]             head_valid,
  input  logic                   slot0_basic,
  input  logic                   slot0_complex,
  input  logic                   slot0_wren,
  input  logic                   slot1_basic,
  input  logic                   slot1_rden1,
  input  logic                   slot1_rden2,
  input  logic                   slot0_return_pop,
  input  logic                   slot0_return_push,
  input  logic                   slot0_jump_uncond,
  input  logic                   slot0_jump_rest,
  input  logic                   slot0_branch,
  output logic [1:0]             take,
  output logic [31:0]            pc0,
  output logic [31:0]            pc1,
  output logic [31:0]            npc0,
  output logic [31:0]            npc1,
  output issue_pkg::instr_word_t instr0,
  output issue_pkg::instr_word_t instr1,
  output logic                   return_pop,
  output logic                   return_push,
  output logic                   jump_uncond,
  output logic                   jump_rest,
  output logic                   branch
);

  import issue_pkg::*;

  logic       raw_hazard;
  logic [1:0] avail;
  logic       issue0;
  logic       issue1;

  // slot 1 reads what slot 0 writes
  assign raw_hazard = slot0_wren &
                      ((slot1_rden1 & (head_instr1.int_form.rs1 == head_instr0.int_form.rd)) |
                       (slot1_rden2 & (head_instr1.int_form.rs2 == head_instr0.int_form.rd)));

  assign avail = head_valid[1] ? 2'd2 : (head_valid[0] ? 2'd1 : 2'd0);

  always_comb begin
    if (slot1_basic && (slot0_basic || slot0_complex) && !raw_hazard) begin
      take = 2'd2;
    end else begin
      take = 2'd1;
    end
    if (issue_hold) begin
      take = 2'd0;
    end
    if (take > avail) begin
      take = avail;
    end
  end

  assign issue0 = take != 2'd0;
  assign issue1 = take == 2'd2;

  assign pc0 = issue0 ? head_pc0 : 32'd0;
  assign pc1 = issue1 ? head_pc1 : 32'd0;

  // compressed encodings step by two bytes
  assign npc0 = !issue0 ? 32'd0 :
                head_pc0 + ((head_instr0.int_form.opcode[1:0] == 2'b11) ? 32'd4 : 32'd2);
  assign npc1 = !issue1 ? 32'd0 :
                head_pc1 + ((head_instr1.int_form.opcode[1:0] == 2'b11) ? 32'd4 : 32'd2);

  assign instr0 = issue0 ? head_instr0 : nop_instr;
  assign instr1 = issue1 ? head_instr1 : nop_instr;

  assign return_pop  = issue0 & slot0_return_pop;
  assign return_push = issue0 & slot0_return_push;
  assign jump_uncond = issue0 & slot0_jump_uncond;
  assign jump_rest   = issue0 & slot0_jump_rest;
  assign branch      = issue0 & slot0_branch;

endmodule

/* src/issue_stage.sv */
`timescale 1ns/1ps

module issue_stage (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   clear,
  input  logic                   ready,
  input  logic [31:0]            fetch_pc,
  input  logic [63:0]            fetch_rdata,
  input  logic                   issue_hold,
  output logic [31:0]            pc0,
  output logic [31:0]            pc1,
  output logic [31:0]            npc0,
  output logic [31:0]            npc1,
  output issue_pkg::instr_word_t instr0,
  output issue_pkg::instr_word_t instr1,
  output logic                   return_pop,
  output logic                   return_push,
  output logic                   jump_uncond,
  output logic                   jump_rest,
  output logic                   branch,
  output logic                   fetch_stall
);

  import issue_pkg::*;

  logic [31:0] head_pc0;
  logic [31:0] head_pc1;
  instr_word_t head_instr0;
  instr_word_t head_instr1;
  logic [1:0]  head_valid;
  logic [1:0]  take;

  logic        slot0_basic;
  logic        slot0_complex;
  logic        slot0_wren;
  logic        slot0_return_pop;
  logic        slot0_return_push;
  logic        slot0_jump_uncond;
  logic        slot0_jump_rest;
  logic        slot0_branch;
  logic        slot1_basic;
  logic        slot1_rden1;
  logic        slot1_rden2;

  fetch_queue i_fetch_queue (
    .clock       (clock),
    .reset       (reset),
    .clear       (clear),
    .ready       (ready),
    .fetch_pc    (fetch_pc),
    .fetch_rdata (fetch_rdata),
    .take        (take),
    .head_pc0    (head_pc0),
    .head_pc1    (head_pc1),
    .head_instr0 (head_instr0),
    .head_instr1 (head_instr1),
    .head_valid  (head_valid),
    .fetch_stall (fetch_stall)
  );

  slot_decoder decode_slot0 (
    .instr       (head_instr0),
    .basic       (slot0_basic),
    .complex     (slot0_complex),
    .wren        (slot0_wren),
    .rden1       (),
    .rden2       (),
    .return_pop  (slot0_return_pop),
    .return_push (slot0_return_push),
    .jump_uncond (slot0_jump_uncond),
    .jump_rest   (slot0_jump_rest),
    .branch      (slot0_branch)
  );

  // only class and source enables matter for the younger slot
  slot_decoder decode_slot1 (
    .instr       (head_instr1),
    .basic       (slot1_basic),
    .complex     (),
    .wren        (),
    .rden1       (slot1_rden1),
    .rden2       (slot1_rden2),
    .return_pop  (),
    .return_push (),
    .jump_uncond (),
    .jump_rest   (),
    .branch      ()
  );

  pair_issue i_pair_issue (
    .issue_hold        (issue_hold),
    .head_pc0          (head_pc0),
    .head_pc1          (head_pc1),
    .head_instr0       (head_instr0),
    .head_instr1       (head_instr1),
    .head_valid        (head_valid),
    .slot0_basic       (slot0_basic),
    .slot0_complex     (slot0_complex),
    .slot0_wren        (slot0_wren),
    .slot1_basic       (slot1_basic),
    .slot1_rden1       (slot1_rden1),
    .slot1_rden2       (slot1_rden2),
    .slot0_return_pop  (slot0_return_pop),
    .slot0_return_push (slot0_return_push),
    .slot0_jump_uncond (slot0_jump_uncond),
    .slot0_jump_rest   (slot0_jump_rest),
    .slot0_branch      (slot0_branch),
    .take              (take),
    .pc0               (pc0),
    .pc1               (pc1),
    .npc0              (npc0),
    .npc1              (npc1),
    .instr0            (instr0),
    .instr1            (instr1),
    .return_pop        (return_pop),
    .return_push       (return_push),
    .jump_uncond       (jump_uncond),
    .jump_rest         (jump_rest),
    .branch            (branch)
  );

endmodule

/* sim/issue_stage_tb.sv */
`timescale 1ns/1ps

module issue_stage_tb;

  import issue_pkg::*;

  localparam int cycle_limit = 400;

  logic        clock;
  logic        reset;
  logic        clear;
  logic        ready;
  logic [31:0] fetch_pc;
  logic [63:0] fetch_rdata;
  logic        issue_hold;

  logic [31:0] pc0;
  logic [31:0] pc1;
  logic [31:0] npc0;
  logic [31:0] npc1;
  instr_word_t instr0;
  instr_word_t instr1;
  logic        return_pop;
  logic        return_push;
  logic        jump_uncond;
  logic        jump_rest;
  logic        branch;
  logic        fetch_stall;
  logic [4:0]  dut_hints;

  // reference queue, entry 0 is the oldest
  logic [31:0] model_pc [queue_depth];
  logic [31:0] model_instr [queue_depth];
  int          model_count;
  logic        model_stall;

  logic [31:0] head0;
  logic [31:0] head1;
  logic [9:0]  cls0;
  logic [9:0]  cls1;
  logic        dep;
  int          exp_take;
  logic [31:0] exp_pc0;
  logic [31:0] exp_pc1;
  logic [31:0] exp_npc0;
  logic [31:0] exp_npc1;
  logic [31:0] exp_instr0;
  logic [31:0] exp_instr1;
  logic [4:0]  exp_hints;

  string       test_name;
  int          cycle_count;

  issue_stage i_issue_stage (
    .clock       (clock),
    .reset       (reset),
    .clear       (clear),
    .ready       (ready),
    .fetch_pc    (fetch_pc),
    .fetch_rdata (fetch_rdata),
    .issue_hold  (issue_hold),
    .pc0         (pc0),
    .pc1         (pc1),
    .npc0        (npc0),
    .npc1        (npc1),
    .instr0      (instr0),
    .instr1      (instr1),
    .return_pop  (return_pop),
    .return_push (return_push),
    .jump_uncond (jump_uncond),
    .jump_rest   (jump_rest),
    .branch      (branch),
    .fetch_stall (fetch_stall)
  );

  assign dut_hints = {return_pop, return_push, jump_uncond, jump_rest, branch};

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  // bits 9..0: basic complex wren rden1 rden2 pop push uncond rest branch
  function automatic logic [9:0] classify(input logic [31:0] w);
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [2:0] f3;
    logic [6:0] f7;
    logic [4:0] f5;
    logic [9:0] c;
    rd = w[11:7];
    rs1 = w[19:15];
    f3 = w[14:12];
    f7 = w[31:25];
    f5 = w[31:27];
    c = '0;
    case (w[6:0])
      opcode_register: begin
        c[9] = f7 == funct7_base ||
               (f7 == funct7_alt && (f3 == funct3_add || f3 == funct3_srl));
        c[8] = !c[9];
        c[7:5] = {rd != 5'd0, 2'b11};
      end
      opcode_immediate: begin
        if (f3 == funct3_sll) begin
          c[9] = f7 == funct7_base;
        end else if (f3 == funct3_srl) begin
          c[9] = f7 == funct7_base || f7 == funct7_alt;
        end else begin
          c[9] = 1'b1;
        end
        c[8] = !c[9];
        c[7:5] = {rd != 5'd0, 2'b10};
      end
      opcode_load: c[8:5] = {1'b1, rd != 5'd0, 2'b10};
      opcode_branch: c[8:0] = 9'b1_0110_0001;
      opcode_jal: begin
        c[8:7] = {1'b1, rd != 5'd0};
        c[3] = rd == link_reg_ra || rd == link_reg_t0;
        c[2] = rd == 5'd0;
        c[1] = !c[3] && !c[2];
      end
      opcode_jalr: begin
        c[8:5] = {1'b1, rd != 5'd0, 2'b10};
        c[4] = rs1 == link_reg_ra || rs1 == link_reg_t0;
        c[3] = rd == link_reg_ra || rd == link_reg_t0;
        c[1] = !c[3];
      end
      opcode_fp: begin
        c[8] = 1'b1;
        // compare and moves or converts to integer write the integer file
        c[7] = f5 == funct5_fcomp || f5 == funct5_fmv_f2i || f5 == funct5_fconv_f2i;
      end
      default: c = '0;
    endcase
    return c;
  endfunction

  always_comb begin
    head0 = model_count > 0 ? model_instr[0] : nop_instr;
    head1 = model_count > 1 ? model_instr[1] : nop_instr;
    cls0 = classify(head0);
    cls1 = classify(head1);
    dep = cls0[7] && ((cls1[6] && head1[19:15] == head0[11:7]) ||
                      (cls1[5] && head1[24:20] == head0[11:7]));
    exp_take = (cls1[9] && (cls0[9] || cls0[8]) && !dep) ? 2 : 1;
    if (issue_hold) begin
      exp_take = 0;
    end
    if (exp_take > model_count) begin
      exp_take = model_count;
    end
    exp_pc0 = exp_take > 0 ? model_pc[0] : 32'd0;
    exp_pc1 = exp_take > 1 ? model_pc[1] : 32'd0;
    exp_npc0 = exp_take > 0 ? model_pc[0] + (head0[1:0] == 2'b11 ? 32'd4 : 32'd2) : 32'd0;
    exp_npc1 = exp_take > 1 ? model_pc[1] + (head1[1:0] == 2'b11 ? 32'd4 : 32'd2) : 32'd0;
    exp_instr0 = exp_take > 0 ? head0 : nop_instr;
    exp_instr1 = exp_take > 1 ? head1 : nop_instr;
    exp_hints = exp_take > 0 ? cls0[4:0] : 5'd0;
  end

  always @(posedge clock) begin
    int   next_count;
    logic accept;
    accept = ready && !model_stall && !clear;
    next_count = model_count - exp_take;
    if (!reset || clear) begin
      model_count <= 0;
      model_stall <= 1'b0;
    end else begin
      for (int i = 0; i < queue_depth; i++) begin
        if (i + exp_take < queue_depth) begin
          model_pc[i] <= model_pc[i + exp_take];
          model_instr[i] <= model_instr[i + exp_take];
        end
      end
      if (accept) begin
        model_pc[next_count] <= fetch_pc;
        model_instr[next_count] <= fetch_rdata[31:0];
        model_pc[next_count + 1] <= fetch_pc + 32'd4;
        model_instr[next_count + 1] <= fetch_rdata[63:32];
        next_count = next_count + 2;
      end
      model_count <= next_count;
      model_stall <= next_count > queue_depth / 2;
    end
  end

  task automatic report_mismatch(input string signal_name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("CHECK FAILED test=%s signal=%s expected=%h actual=%h",
             test_name, signal_name, expected, actual);
    $display("Result: FAILED");
    $fatal(1, "output differs from the queue model");
  endtask

  assert property (@(posedge clock) disable iff (!reset) pc0 == exp_pc0)
    else report_mismatch("pc0", $sampled(exp_pc0), $sampled(pc0));
  assert property (@(posedge clock) disable iff (!reset) pc1 == exp_pc1)
    else report_mismatch("pc1", $sampled(exp_pc1), $sampled(pc1));
  assert property (@(posedge clock) disable iff (!reset) npc0 == exp_npc0)
    else report_mismatch("npc0", $sampled(exp_npc0), $sampled(npc0));
  assert property (@(posedge clock) disable iff (!reset) npc1 == exp_npc1)
    else report_mismatch("npc1", $sampled(exp_npc1), $sampled(npc1));
  assert property (@(posedge clock) disable iff (!reset) instr0 == exp_instr0)
    else report_mismatch("instr0", $sampled(exp_instr0), $sampled(instr0));
  assert property (@(posedge clock) disable iff (!reset) instr1 == exp_instr1)
    else report_mismatch("instr1", $sampled(exp_instr1), $sampled(instr1));
  // pop push uncond rest branch
  assert property (@(posedge clock) disable iff (!reset) dut_hints == exp_hints)
    else report_mismatch("hints", $sampled(exp_hints), $sampled(dut_hints));
  assert property (@(posedge clock) disable iff (!reset) fetch_stall == model_stall)
    else report_mismatch("fetch_stall", $sampled(model_stall), $sampled(fetch_stall));

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: the stimulus did not finish within %0d cycles", cycle_limit);
      $display("Result: FAILED");
      $fatal(1, "cycle limit reached");
    end
  end

  function automatic logic [31:0] r_op(input logic [6:0] f7, input logic [2:0] f3,
                                       input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, opcode_register};
  endfunction

  // zero immediate
  function automatic logic [31:0] i_op(input logic [6:0] op, input logic [2:0] f3,
                                       input logic [4:0] rd, input logic [4:0] rs1);
    return {12'd0, rs1, f3, rd, op};
  endfunction

  function automatic logic [4:0] pick_dest();
    return 5'(1 + $urandom % 15);
  endfunction

  function automatic logic [4:0] pick_src();
    return 5'(16 + $urandom % 16);
  endfunction

  task automatic send_word(input logic [31:0] pc, input logic [31:0] lo, input logic [31:0] hi);
    @(posedge clock);
    ready <= 1'b1;
    fetch_pc <= pc;
    fetch_rdata <= {hi, lo};
    @(posedge clock);
    ready <= 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clock);
  endtask

  // issue outputs go idle once the queue has drained
  task automatic wait_idle();
    @(negedge clock);
    while (pc0 != 32'd0) begin
      @(negedge clock);
    end
  endtask

  initial begin
    logic [4:0]  rd_a;
    logic [4:0]  rd_b;
    logic [31:0] hint_ops [5];
    void'($urandom(51));
    reset = 1'b0;
    clear = 1'b0;
    ready = 1'b0;
    fetch_pc = 32'd0;
    fetch_rdata = 64'd0;
    issue_hold = 1'b0;
    test_name = "reset";
    repeat (2) @(posedge clock);
    reset <= 1'b1;
    idle_cycles(3);

    test_name = "pair_issue";
    rd_a = pick_dest();
    rd_b = pick_dest();
    send_word(32'h100, r_op(funct7_base, funct3_add, rd_a, pick_src(), pick_src()),
              r_op(funct7_base, funct3_xor, rd_b, pick_src(), pick_src()));
    send_word(32'h108, r_op(funct7_alt, funct3_add, rd_b, pick_src(), pick_src()),
              32'h0000_4505);
    wait_idle();

    test_name = "single_issue";
    rd_a = pick_dest();
    rd_b = pick_dest();
    send_word(32'h200, r_op(funct7_base, funct3_add, rd_a, pick_src(), pick_src()),
              r_op(funct7_base, funct3_or, rd_b, rd_a, pick_src()));
    wait_idle();
    send_word(32'h210, r_op(funct7_base, funct3_and, rd_a, pick_src(), pick_src()),
              r_op(funct7_base, funct3_sll, rd_b, pick_src(), rd_a));
    wait_idle();
    send_word(32'h220, r_op(funct7_base, funct3_add, rd_a, pick_src(), pick_src()),
              i_op(opcode_load, 3'b010, rd_b, pick_src()));
    wait_idle();
    send_word(32'h230, r_op(funct7_base, funct3_add, rd_a, pick_src(), pick_src()),
              {funct5_fadd, 2'b00, pick_src(), pick_src(), 3'b111, rd_b, opcode_fp});
    wait_idle();
    @(posedge clock);
    issue_hold <= 1'b1;
    send_word(32'h240, r_op(funct7_base, funct3_add, rd_a, pick_src(), pick_src()),
              r_op(funct7_base, funct3_sltu, rd_b, pick_src(), pick_src()));
    idle_cycles(3);
    issue_hold <= 1'b0;
    wait_idle();

    test_name = "hints";
    hint_ops[0] = {20'd0, link_reg_ra, opcode_jal};
    hint_ops[1] = {20'd0, 5'd0, opcode_jal};
    hint_ops[2] = i_op(opcode_jalr, 3'b000, 5'd0, link_reg_ra);
    hint_ops[3] = {20'd0, 5'd3, opcode_jal};
    hint_ops[4] = {7'd0, 5'd7, 5'd6, 3'b000, 5'd0, opcode_branch};
    for (int i = 0; i < 5; i++) begin
      send_word(32'h400 + 32'(i * 16), hint_ops[i],
                r_op(funct7_base, funct3_add, 5'd20, 5'd21, 5'd22));
      wait_idle();
    end

    test_name = "stall_clear";
    @(posedge clock);
    issue_hold <= 1'b1;
    for (int i = 0; i < 4; i++) begin
      send_word(32'h500 + 32'(i * 8), r_op(funct7_base, funct3_add, pick_dest(), 5'd20, 5'd21),
                r_op(funct7_base, funct3_xor, pick_dest(), 5'd22, 5'd23));
    end
    idle_cycles(1);
    clear <= 1'b1;
    @(posedge clock);
    clear <= 1'b0;
    idle_cycles(2);
    issue_hold <= 1'b0;
    idle_cycles(3);

    $display("Result: PASSED");
    $finish;
  end

endmodule

/* build.f */
src/issue_pkg.sv
src/fetch_queue.sv
src/slot_decoder.sv
src/pair_issue.sv
src/issue_stage.sv
sim/issue_stage_tb.sv

/* run.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module issue_stage_tb &&
./obj_dir/Vissue_stage_tb | tee /dev/stderr | grep -q "Result: PASSED" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
